//--- vga_tile_display.f
+incdir+rtl
rtl/vga_pkg.sv
rtl/vga_timing.sv
rtl/host_tile_port.sv
rtl/tile_mem_arbiter.sv
rtl/tile_ram.sv
rtl/pixel_compose.sv
rtl/vga_tile_display.sv
bench/clk_gen.sv
bench/tb_vga_tile_display.sv

//--- Bender.yml
package:
  name: vga_tile_display

export_include_dirs:
  - rtl

sources:
  # rtl/vga_settings.svh is found through the rtl include directory
  - include_dirs:
      - rtl
    files:
      - rtl/vga_pkg.sv
      - rtl/vga_timing.sv
      - rtl/host_tile_port.sv
      - rtl/tile_mem_arbiter.sv
      - rtl/tile_ram.sv
      - rtl/pixel_compose.sv
      - rtl/vga_tile_display.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/clk_gen.sv
      - bench/tb_vga_tile_display.sv

//--- bench/tb_vga_tile_display.sv
`timescale 1ns/1ps
`include "vga_settings.svh"

module tb_vga_tile_display;

    localparam int H_TOTAL = `VGA_H_TOTAL;
    localparam int V_TOTAL = `VGA_V_TOTAL;
    localparam int HS_START = `VGA_H_DISPLAY + `VGA_H_FRONT;
    localparam int VS_START = `VGA_V_DISPLAY + `VGA_V_FRONT;
    localparam int TILE_ROWS = `VGA_V_DISPLAY / `VGA_TILE_H;
    localparam int TILE_VIS_COLS = `VGA_H_DISPLAY / `VGA_TILE_W;
    // From the drive edge after vsync falls to line 100 of the next frame
    localparam int TO_ACTIVE = (V_TOTAL - VS_START + 100) * H_TOTAL + 97;
    localparam int BURST_GAP = 40 * H_TOTAL - 4;
    localparam int VSYNC_TIMEOUT = V_TOTAL * H_TOTAL + 100;

    logic                 clk;
    logic                 rst;
    vga_pkg::vga_mode_t   mode;
    logic                 host_we;
    vga_pkg::tile_write_t host_wr;
    vga_pkg::rgb_t        rgb;
    logic                 hsync;
    logic                 vsync;

    vga_pkg::rgb_t        tile_model [0:255];  // Follows every issued write
    vga_pkg::rgb_t        tile_shown [0:255];  // Copy taken at frame start
    vga_pkg::vga_mode_t   frame_mode;
    logic [31:0]          lfsr_state = 32'd99;
    int                   model_h;
    int                   model_v;
    int                   errors = 0;

    clk_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    vga_tile_display UUT (
        .clk     (clk),
        .rst     (rst),
        .mode    (mode),
        .host_we (host_we),
        .host_wr (host_wr),
        .rgb     (rgb),
        .hsync   (hsync),
        .vsync   (vsync)
    );

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic hsync_level(int h);
        return !(h >= HS_START && h < HS_START + `VGA_H_SYNC);
    endfunction

    function automatic logic vsync_level(int v);
        return !(v >= VS_START && v < VS_START + `VGA_V_SYNC);
    endfunction

    function automatic vga_pkg::rgb_t pixel_color(int h, int v, vga_pkg::vga_mode_t m);
        if (h >= `VGA_H_DISPLAY || v >= `VGA_V_DISPLAY) begin
            return '0;
        end
        if (m == vga_pkg::MODE_TILES) begin
            return tile_shown[(v / `VGA_TILE_H) * `VGA_TILE_COLS + h / `VGA_TILE_W];
        end
        if (h < 160) begin
            return 24'hFF_0000;
        end else if (h < 320) begin
            return 24'h00_FF00;
        end else if (h < 480) begin
            return 24'h00_00FF;
        end
        return 24'hFF_FFFF;  // White bar
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    // Random visible tile and random color
    task automatic make_write(output vga_pkg::tile_write_t w);
        logic [31:0] row;
        logic [31:0] col;
        logic [31:0] color;
        take_bits(4, row);
        take_bits(4, col);
        take_bits(24, color);
        w.addr  = vga_pkg::tile_addr_t'((row % TILE_ROWS) * `VGA_TILE_COLS
                                        + col % TILE_VIS_COLS);
        w.color = color[23:0];
    endtask

    // Strobes on consecutive edges
    task automatic strobe_burst(input int count, input logic all_land);
        vga_pkg::tile_write_t w;
        for (int i = 0; i < count; i++) begin
            make_write(w);
            @(posedge clk);
            host_we <= 1'b1;
            host_wr <= w;
            if (all_land) begin
                tile_model[w.addr] = w.color;  // Granted while the next one arrives
            end
        end
        @(posedge clk);
        host_we <= 1'b0;
        tile_model[w.addr] = w.color;  // Newest write always survives
    endtask

    task automatic wait_vsync_fall();
        logic prev;
        logic found;
        @(negedge clk);
        prev  = vsync;
        found = 1'b0;
        for (int i = 0; i < VSYNC_TIMEOUT && !found; i++) begin
            @(negedge clk);
            found = (prev === 1'b1) && (vsync === 1'b0);
            prev  = vsync;
        end
        if (!found) begin
            $display("Timed out waiting for the falling edge of vsync");
            $display("Errors found");
            $fatal(1, "vsync wait timeout");
        end
    endtask

    task automatic check_sync(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %b, expected %b at h=%0d v=%0d",
                     $time, name, got, exp, model_h, model_v);
            $display("Errors found");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic check_rgb(input vga_pkg::rgb_t got, input vga_pkg::rgb_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: rgb is %h, expected %h at h=%0d v=%0d",
                     $time, got, exp, model_h, model_v);
            $display("Errors found");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Compare on the falling edge where outputs are settled
    initial begin
        int guard;
        guard   = 0;
        model_h = 0;
        model_v = 0;
        @(negedge clk);
        while (rst) begin
            check_sync(hsync, 1'b1, "hsync");
            check_sync(vsync, 1'b1, "vsync");
            check_rgb(rgb, '0);
            guard++;
            if (guard > 16) begin
                $display("Reset was never released");
                $display("Errors found");
                $fatal(1, "reset timeout");
            end
            @(negedge clk);
        end
        // Pipeline still holds reset values for 2 cycles
        repeat (2) begin
            check_sync(hsync, 1'b1, "hsync");
            check_sync(vsync, 1'b1, "vsync");
            check_rgb(rgb, '0);
            @(negedge clk);
        end
        forever begin
            if (model_h == 0 && model_v == 0) begin
                frame_mode = mode;
                tile_shown = tile_model;  // Writes count from this frame on
            end
            check_sync(hsync, hsync_level(model_h), "hsync");
            check_sync(vsync, vsync_level(model_v), "vsync");
            check_rgb(rgb, pixel_color(model_h, model_v, frame_mode));
            if (model_h == H_TOTAL - 1) begin
                model_h = 0;
                model_v = (model_v == V_TOTAL - 1) ? 0 : model_v + 1;
            end else begin
                model_h++;
            end
            @(negedge clk);
        end
    end

    initial begin
        mode    = vga_pkg::MODE_BARS;
        host_we = 1'b0;
        host_wr = '0;
        for (int i = 0; i < 256; i++) begin
            tile_model[i] = '0;
            tile_shown[i] = '0;
        end

        // Frame 0 shows bars
        wait_vsync_fall();
        @(posedge clk);
        mode <= vga_pkg::MODE_TILES;
        // Vertical blanking writes, each strobe meets the grant of the one before
        for (int i = 0; i < 8; i++) begin
            strobe_burst(2, 1'b1);
        end

        // Frame 1 shows tiles
        wait_vsync_fall();
        @(posedge clk);
        mode <= vga_pkg::MODE_BARS;
        repeat (TO_ACTIVE) @(posedge clk);
        // Back-to-back strobes inside the active area of frame 2
        for (int i = 0; i < 4; i++) begin
            strobe_burst(3, 1'b0);
            repeat (BURST_GAP) @(posedge clk);
        end

        // Frame 3 shows every surviving write
        wait_vsync_fall();
        @(posedge clk);
        mode <= vga_pkg::MODE_TILES;
        wait_vsync_fall();
        repeat (100) @(posedge clk);

        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset spans the first two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- rtl/vga_tile_display.sv
`timescale 1ns/1ps
`include "vga_settings.svh"

module vga_tile_display (
    input  logic                 clk,
    input  logic                 rst,
    input  vga_pkg::vga_mode_t   mode,
    input  logic                 host_we,
    input  vga_pkg::tile_write_t host_wr,
    output vga_pkg::rgb_t        rgb,
    output logic                 hsync,
    output logic                 vsync
);

    vga_pkg::vga_pos_t    pos;
    logic                 rd_req;
    vga_pkg::tile_addr_t  rd_addr;
    vga_pkg::rgb_t        rd_data;
    logic                 wr_req;
    logic                 wr_gnt;
    vga_pkg::tile_write_t wr_data;
    logic                 mem_en;
    logic                 mem_we;
    vga_pkg::tile_addr_t  mem_addr;
    vga_pkg::rgb_t        mem_wdata;

    vga_timing u_timing (
        .clk (clk),
        .rst (rst),
        .pos (pos)
    );

    pixel_compose u_compose (
        .clk     (clk),
        .rst     (rst),
        .mode    (mode),
        .pos     (pos),
        .rd_data (rd_data),
        .rd_req  (rd_req),
        .rd_addr (rd_addr),
        .rgb     (rgb),
        .hsync   (hsync),
        .vsync   (vsync)
    );

    host_tile_port u_host (
        .clk     (clk),
        .rst     (rst),
        .host_we (host_we),
        .host_wr (host_wr),
        .wr_gnt  (wr_gnt),
        .wr_req  (wr_req),
        .wr_data (wr_data)
    );

    tile_mem_arbiter u_arb (
        .clk       (clk),
        .rst       (rst),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .wr_req    (wr_req),
        .wr_data   (wr_data),
        .wr_gnt    (wr_gnt),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    tile_ram u_ram (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (rd_data)
    );

    // A pending host write lands within one line at most
    write_within_line: assert property (@(posedge clk) disable iff (rst)
        wr_req |-> ##[0:`VGA_H_TOTAL] wr_gnt);

endmodule

//--- rtl/pixel_compose.sv
`timescale 1ns/1ps
`include "vga_settings.svh"

module pixel_compose (
    input  logic                clk,
    input  logic                rst,
    input  vga_pkg::vga_mode_t  mode,
    input  vga_pkg::vga_pos_t   pos,
    input  vga_pkg::rgb_t       rd_data,
    output logic                rd_req,
    output vga_pkg::tile_addr_t rd_addr,
    output vga_pkg::rgb_t       rgb,
    output logic                hsync,
    output logic                vsync
);

    localparam vga_pkg::coord_t TILE_W = vga_pkg::coord_t'(`VGA_TILE_W);
    localparam vga_pkg::coord_t TILE_H = vga_pkg::coord_t'(`VGA_TILE_H);
    localparam vga_pkg::coord_t TILE_COLS = vga_pkg::coord_t'(`VGA_TILE_COLS);

    // Bar edges at quarters of the visible width
    localparam vga_pkg::coord_t BAR_1 = vga_pkg::coord_t'(`VGA_H_DISPLAY / 4);
    localparam vga_pkg::coord_t BAR_2 = vga_pkg::coord_t'(`VGA_H_DISPLAY / 2);
    localparam vga_pkg::coord_t BAR_3 = vga_pkg::coord_t'(3 * `VGA_H_DISPLAY / 4);

    vga_pkg::coord_t tile_row;
    vga_pkg::coord_t tile_col;
    vga_pkg::coord_t tile_index;
    vga_pkg::rgb_t   bar_color;
    vga_pkg::rgb_t   bar_q;
    logic            active_q;
    logic            hsync_q;
    logic            vsync_q;

    // Tile lookup for the current pixel
    assign tile_row   = pos.v / TILE_H;
    assign tile_col   = pos.h / TILE_W;
    assign tile_index = tile_row * TILE_COLS + tile_col;
    assign rd_addr    = tile_index[$bits(vga_pkg::tile_addr_t)-1:0];
    assign rd_req     = pos.active;

    always_comb begin
        if (pos.h < BAR_1) begin
            bar_color = '{red: 8'hFF, green: 8'h00, blue: 8'h00};
        end else if (pos.h < BAR_2) begin
            bar_color = '{red: 8'h00, green: 8'hFF, blue: 8'h00};
        end else if (pos.h < BAR_3) begin
            bar_color = '{red: 8'h00, green: 8'h00, blue: 8'hFF};
        end else begin
            bar_color = '{red: 8'hFF, green: 8'hFF, blue: 8'hFF};  // White bar
        end
    end

    // First stage runs alongside the RAM read
    always_ff @(posedge clk) begin
        bar_q <= bar_color;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active_q <= 1'b0;
            hsync_q  <= 1'b1;
            vsync_q  <= 1'b1;
        end else begin
            active_q <= pos.active;
            hsync_q  <= pos.hsync_n;
            vsync_q  <= pos.vsync_n;
        end
    end

    // Output stage, RAM data is valid here
    always_ff @(posedge clk) begin
        if (rst) begin
            rgb   <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            hsync <= hsync_q;
            vsync <= vsync_q;
            if (!active_q) begin
                rgb <= '0;  // Blanking
            end else if (mode == vga_pkg::MODE_TILES) begin
                rgb <= rd_data;
            end else begin
                rgb <= bar_q;
            end
        end
    end

endmodule

//--- rtl/tile_ram.sv
`timescale 1ns/1ps

module tile_ram (
    input  logic                clk,
    input  logic                en,
    input  logic                we,
    input  vga_pkg::tile_addr_t addr,
    input  vga_pkg::rgb_t       wdata,
    output vga_pkg::rgb_t       rdata
);

    vga_pkg::rgb_t mem [0:255];

    // Start from an all-black map
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];  // One cycle read latency
            end
        end
    end

endmodule

//--- rtl/tile_mem_arbiter.sv
`timescale 1ns/1ps

module tile_mem_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rd_req,
    input  vga_pkg::tile_addr_t  rd_addr,
    input  logic                 wr_req,
    input  vga_pkg::tile_write_t wr_data,
    output logic                 wr_gnt,
    output logic                 mem_en,
    output logic                 mem_we,
    output vga_pkg::tile_addr_t  mem_addr,
    output vga_pkg::rgb_t        mem_wdata
);

    typedef enum logic {
        OWN_VIDEO,
        OWN_HOST
    } owner_t;

    owner_t last_owner;

    assign mem_wdata = wr_data.color;

    // Fixed priority, the video read always wins
    always_comb begin
        wr_gnt   = 1'b0;
        mem_en   = 1'b0;
        mem_we   = 1'b0;
        mem_addr = rd_addr;
        if (rd_req) begin
            mem_en = 1'b1;
        end else if (wr_req) begin
            mem_en   = 1'b1;
            mem_we   = 1'b1;
            mem_addr = wr_data.addr;
            wr_gnt   = 1'b1;
        end
    end

    // Owner of the last command actually sent to the RAM
    always_ff @(posedge clk) begin
        if (rst) begin
            last_owner <= OWN_VIDEO;
        end else if (mem_en && !mem_we) begin
            last_owner <= OWN_VIDEO;
        end else if (mem_en && mem_we) begin
            last_owner <= OWN_HOST;
        end
    end

    read_never_denied: assert property (@(posedge clk) disable iff (rst)
        rd_req |=> last_owner == OWN_VIDEO);

    write_takes_port: assert property (@(posedge clk) disable iff (rst)
        wr_gnt |=> last_owner == OWN_HOST);

endmodule

//--- rtl/host_tile_port.sv
`timescale 1ns/1ps

module host_tile_port (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 host_we,
    input  vga_pkg::tile_write_t host_wr,
    input  logic                 wr_gnt,
    output logic                 wr_req,
    output vga_pkg::tile_write_t wr_data
);

    // Pending flag, a fresh strobe wins over a grant
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_req <= 1'b0;
        end else if (host_we) begin
            wr_req <= 1'b1;
        end else if (wr_gnt) begin
            wr_req <= 1'b0;
        end
    end

    // Held write, newest strobe replaces it
    always_ff @(posedge clk) begin
        if (host_we) begin
            wr_data <= host_wr;
        end
    end

    // Arbiter must only grant what was asked for
    gnt_needs_req: assert property (@(posedge clk) disable iff (rst)
        wr_gnt |-> wr_req);

endmodule

//--- rtl/vga_timing.sv
`timescale 1ns/1ps
`include "vga_settings.svh"

module vga_timing (
    input  logic              clk,
    input  logic              rst,
    output vga_pkg::vga_pos_t pos
);

    localparam vga_pkg::coord_t H_LAST = vga_pkg::coord_t'(`VGA_H_TOTAL - 1);
    localparam vga_pkg::coord_t V_LAST = vga_pkg::coord_t'(`VGA_V_TOTAL - 1);
    localparam vga_pkg::coord_t H_DISP = vga_pkg::coord_t'(`VGA_H_DISPLAY);
    localparam vga_pkg::coord_t V_DISP = vga_pkg::coord_t'(`VGA_V_DISPLAY);

    // Sync pulse windows, start inclusive and end exclusive
    localparam vga_pkg::coord_t HS_START = vga_pkg::coord_t'(`VGA_H_DISPLAY + `VGA_H_FRONT);
    localparam vga_pkg::coord_t HS_END = vga_pkg::coord_t'(`VGA_H_DISPLAY + `VGA_H_FRONT
                                                           + `VGA_H_SYNC);
    localparam vga_pkg::coord_t VS_START = vga_pkg::coord_t'(`VGA_V_DISPLAY + `VGA_V_FRONT);
    localparam vga_pkg::coord_t VS_END = vga_pkg::coord_t'(`VGA_V_DISPLAY + `VGA_V_FRONT
                                                           + `VGA_V_SYNC);

    vga_pkg::coord_t h_cnt;
    vga_pkg::coord_t v_cnt;
    logic            line_end;

    assign line_end = (h_cnt == H_LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt <= '0;
        end else if (line_end) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    // Line counter steps once per line
    always_ff @(posedge clk) begin
        if (rst) begin
            v_cnt <= '0;
        end else if (line_end) begin
            if (v_cnt == V_LAST) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 10'd1;
            end
        end
    end

    always_comb begin
        pos.h       = h_cnt;
        pos.v       = v_cnt;
        pos.active  = (h_cnt < H_DISP) && (v_cnt < V_DISP);
        pos.hsync_n = !((h_cnt >= HS_START) && (h_cnt < HS_END));
        pos.vsync_n = !((v_cnt >= VS_START) && (v_cnt < VS_END));
    end

    h_in_range: assert property (@(posedge clk) disable iff (rst) h_cnt <= H_LAST);

    // Lines only advance across the wrap of h
    v_on_wrap: assert property (@(posedge clk) disable iff (rst)
        !$stable(v_cnt) |-> $past(line_end));

endmodule

//--- rtl/vga_pkg.sv
package vga_pkg;

    // Counter or screen coordinate
    typedef logic [9:0] coord_t;

    // One color channel
    typedef logic [7:0] color8_t;

    // Tile RAM address, row * 16 + column
    typedef logic [7:0] tile_addr_t;

    typedef struct packed {
        color8_t red;
        color8_t green;
        color8_t blue;
    } rgb_t;

    // Raster position and the flags that belong to it
    typedef struct packed {
        coord_t h;
        coord_t v;
        logic   active;
        logic   hsync_n;  // Low during the sync pulse
        logic   vsync_n;
    } vga_pos_t;

    // One host write to the tile map
    typedef struct packed {
        tile_addr_t addr;
        rgb_t       color;
    } tile_write_t;

    typedef enum logic {
        MODE_BARS,
        MODE_TILES
    } vga_mode_t;

endpackage

//--- rtl/vga_settings.svh
`ifndef VGA_SETTINGS_SVH
`define VGA_SETTINGS_SVH

// Horizontal timing in pixel clocks
`define VGA_H_DISPLAY 640
`define VGA_H_FRONT   16
`define VGA_H_SYNC    96
`define VGA_H_BACK    48

// Vertical timing in lines
`define VGA_V_DISPLAY 480
`define VGA_V_FRONT   10
`define VGA_V_SYNC    2
`define VGA_V_BACK    33

// Full line and frame lengths
`define VGA_H_TOTAL (`VGA_H_DISPLAY + `VGA_H_FRONT + `VGA_H_SYNC + `VGA_H_BACK)
`define VGA_V_TOTAL (`VGA_V_DISPLAY + `VGA_V_FRONT + `VGA_V_SYNC + `VGA_V_BACK)

// Tile geometry
`define VGA_TILE_W    64
`define VGA_TILE_H    32

// Address stride per tile row, only 10 columns are on screen
`define VGA_TILE_COLS 16

`endif
